// ==== Bender.yml ====
package:
  name: vgaDisplay

sources:
  - hdl/vgaPkg.sv
  - hdl/vgaTiming.sv
  - hdl/patternRenderer.sv
  - hdl/pixelFifo.sv
  - hdl/pixelOutput.sv
  - hdl/vgaDisplayTop.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/vgaDisplayTb.sv

// ==== files.f ====
hdl/vgaPkg.sv
hdl/vgaTiming.sv
hdl/patternRenderer.sv
hdl/pixelFifo.sv
hdl/pixelOutput.sv
hdl/vgaDisplayTop.sv
tests/clockGen.sv
tests/vgaDisplayTb.sv

// ==== hdl/patternRenderer.sv ====
`timescale 1ns/1ns

module patternRenderer
	import vgaPkg::*;
#(
	parameter int displayWidth = 640,
	parameter int displayHeight = 480,
	parameter int coordWidth = 10
) (
	input logic clockVGA,
	input logic rstN,
	input logic full,
	output logic push,
	output pixelT wrData
);

	localparam logic [coordWidth-1:0] xLast = coordWidth'(displayWidth - 1);
	localparam logic [coordWidth-1:0] yLast = coordWidth'(displayHeight - 1);

	logic [coordWidth-1:0] x;
	logic [coordWidth-1:0] y;
	logic [colorWidth-1:0] frameCount;
	logic running;

	// Held low through reset so nothing is pushed early
	always_ff @(posedge clockVGA) begin
		if (!rstN)
			running <= 1'b0;
		else
			running <= 1'b1;
	end

	assign push = running && !full;

	// Walk the active area; a full FIFO freezes the walk
	always_ff @(posedge clockVGA) begin
		if (!rstN) begin
			x <= '0;
			y <= '0;
			frameCount <= '0;
		end else if (push) begin
			if (x == xLast) begin
				x <= '0;
				if (y == yLast) begin
					y <= '0;
					frameCount <= frameCount + 1'b1;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// Coordinate test pattern
	always_comb begin
		wrData.red = x[colorWidth-1:0];
		wrData.green = y[colorWidth-1:0];
		wrData.blue = frameCount;
	end

endmodule

// ==== hdl/pixelFifo.sv ====
`timescale 1ns/1ns

module pixelFifo
	import vgaPkg::*;
#(
	parameter type payloadT = pixelT,
	parameter int depth = 16
) (
	input logic clockVGA,
	input logic rstN,
	input logic push,
	input payloadT wrData,
	input logic pop,
	output payloadT rdData,
	output logic full,
	output logic empty
);

	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int countWidth = $clog2(depth + 1);

	payloadT mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] count;
	logic doPush;
	logic doPop;

	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(depth - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	// Requests against a full or empty buffer are dropped
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	always_ff @(posedge clockVGA) begin
		if (doPush)
			mem[wrPtr] <= wrData;
	end

	always_ff @(posedge clockVGA) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Show-ahead head entry
	assign rdData = mem[rdPtr];
	assign full = (count == countWidth'(depth));
	assign empty = (count == '0);

endmodule

// ==== hdl/pixelOutput.sv ====
`timescale 1ns/1ns

module pixelOutput
	import vgaPkg::*;
(
	input logic clockVGA,
	input logic rstN,
	input logic displayEnable,
	input logic hSyncRaw,
	input logic vSyncRaw,
	input pixelT rdData,
	input logic empty,
	output logic pop,
	output logic hSyncN,
	output logic vSyncN,
	output logic [colorWidth-1:0] red,
	output logic [colorWidth-1:0] green,
	output logic [colorWidth-1:0] blue,
	output logic underrun
);

	pixelT shownPixel;

	// One pixel consumed per active clock
	assign pop = displayEnable;

	// Colour and syncs leave on the same edge
	always_ff @(posedge clockVGA) begin
		if (!rstN) begin
			shownPixel <= '0;
			hSyncN <= 1'b1;
			vSyncN <= 1'b1;
		end else begin
			hSyncN <= ~hSyncRaw;
			vSyncN <= ~vSyncRaw;
			if (displayEnable && !empty)
				shownPixel <= rdData;
			else
				shownPixel <= '0;
		end
	end

	// Sticky until reset
	always_ff @(posedge clockVGA) begin
		if (!rstN)
			underrun <= 1'b0;
		else if (displayEnable && empty)
			underrun <= 1'b1;
	end

	assign red = shownPixel.red;
	assign green = shownPixel.green;
	assign blue = shownPixel.blue;

endmodule

// ==== hdl/vgaDisplayTop.sv ====
`timescale 1ns/1ns

module vgaDisplayTop
	import vgaPkg::*;
#(
	parameter int displayWidth = 640,
	parameter int displayHeight = 480,
	parameter int hSyncTime = 96,
	parameter int hBackTime = 48,
	parameter int hFrontTime = 16,
	parameter int vSyncTime = 2,
	parameter int vBackTime = 33,
	parameter int vFrontTime = 10,
	parameter int fifoDepth = 16,
	parameter int coordWidth = 10
) (
	input logic clockVGA,
	input logic rstN,
	output logic hSyncN,
	output logic vSyncN,
	output logic [colorWidth-1:0] red,
	output logic [colorWidth-1:0] green,
	output logic [colorWidth-1:0] blue,
	output logic underrun
);

	logic displayEnable;
	logic hSyncRaw;
	logic vSyncRaw;
	logic push;
	logic pop;
	logic full;
	logic empty;
	pixelT wrData;
	pixelT rdData;

	vgaTiming #(
		.displayWidth(displayWidth),
		.displayHeight(displayHeight),
		.hSyncTime(hSyncTime),
		.hBackTime(hBackTime),
		.hFrontTime(hFrontTime),
		.vSyncTime(vSyncTime),
		.vBackTime(vBackTime),
		.vFrontTime(vFrontTime),
		.coordWidth(coordWidth)
	) i_timing (
		.clockVGA(clockVGA),
		.rstN(rstN),
		.displayEnable(displayEnable),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw)
	);

	patternRenderer #(
		.displayWidth(displayWidth),
		.displayHeight(displayHeight),
		.coordWidth(coordWidth)
	) i_renderer (
		.clockVGA(clockVGA),
		.rstN(rstN),
		.full(full),
		.push(push),
		.wrData(wrData)
	);

	pixelFifo #(
		.payloadT(pixelT),
		.depth(fifoDepth)
	) i_fifo (
		.clockVGA(clockVGA),
		.rstN(rstN),
		.push(push),
		.wrData(wrData),
		.pop(pop),
		.rdData(rdData),
		.full(full),
		.empty(empty)
	);

	pixelOutput i_output (
		.clockVGA(clockVGA),
		.rstN(rstN),
		.displayEnable(displayEnable),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.rdData(rdData),
		.empty(empty),
		.pop(pop),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.red(red),
		.green(green),
		.blue(blue),
		.underrun(underrun)
	);

endmodule

// ==== hdl/vgaPkg.sv ====
package vgaPkg;

	// Bits per colour channel, RGB444
	localparam int colorWidth = 4;

	typedef struct packed {
		logic [colorWidth-1:0] red;
		logic [colorWidth-1:0] green;
		logic [colorWidth-1:0] blue;
	} pixelT;

	// One-hot raster phase, shared by both axes
	typedef enum logic [3:0] {
		sync       = 4'b0001,
		backPorch  = 4'b0010,
		active     = 4'b0100,
		frontPorch = 4'b1000
	} rasterStateT;

endpackage

// ==== hdl/vgaTiming.sv ====
`timescale 1ns/1ns

module vgaTiming
	import vgaPkg::*;
#(
	parameter int displayWidth = 640,
	parameter int displayHeight = 480,
	parameter int hSyncTime = 96,
	parameter int hBackTime = 48,
	parameter int hFrontTime = 16,
	parameter int vSyncTime = 2,
	parameter int vBackTime = 33,
	parameter int vFrontTime = 10,
	parameter int coordWidth = 10
) (
	input logic clockVGA,
	input logic rstN,
	output logic displayEnable,
	output logic hSyncRaw,
	output logic vSyncRaw
);

	// Phase boundaries, each one past the last count of its phase
	localparam logic [coordWidth-1:0] hSyncEnd = coordWidth'(hSyncTime);
	localparam logic [coordWidth-1:0] hBackEnd = coordWidth'(hSyncTime + hBackTime);
	localparam logic [coordWidth-1:0] hActiveEnd =
		coordWidth'(hSyncTime + hBackTime + displayWidth);
	localparam logic [coordWidth-1:0] hLast =
		coordWidth'(hSyncTime + hBackTime + displayWidth + hFrontTime - 1);

	// Vertical phases are sized by the display height
	localparam logic [coordWidth-1:0] vSyncEnd = coordWidth'(vSyncTime);
	localparam logic [coordWidth-1:0] vBackEnd = coordWidth'(vSyncTime + vBackTime);
	localparam logic [coordWidth-1:0] vActiveEnd =
		coordWidth'(vSyncTime + vBackTime + displayHeight);
	localparam logic [coordWidth-1:0] vLast =
		coordWidth'(vSyncTime + vBackTime + displayHeight + vFrontTime - 1);

	logic [coordWidth-1:0] hCount;
	logic [coordWidth-1:0] vCount;
	rasterStateT hState;
	rasterStateT vState;

	function automatic rasterStateT decodeAxis(
		input logic [coordWidth-1:0] count,
		input logic [coordWidth-1:0] syncEnd,
		input logic [coordWidth-1:0] backEnd,
		input logic [coordWidth-1:0] activeEnd
	);
		if (count < syncEnd)
			return sync;
		else if (count < backEnd)
			return backPorch;
		else if (count < activeEnd)
			return active;
		else
			return frontPorch;
	endfunction

	// Counters start at the sync pulse
	always_ff @(posedge clockVGA) begin
		if (!rstN) begin
			hCount <= '0;
			vCount <= '0;
		end else if (hCount == hLast) begin
			hCount <= '0;
			if (vCount == vLast)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	assign hState = decodeAxis(hCount, hSyncEnd, hBackEnd, hActiveEnd);
	assign vState = decodeAxis(vCount, vSyncEnd, vBackEnd, vActiveEnd);

	assign hSyncRaw = (hState == sync);
	assign vSyncRaw = (vState == sync);
	assign displayEnable = (hState == active) && (vState == active);

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/1ns

module clockGen #(
	parameter int halfPeriod = 2,
	parameter int resetCycles = 16
) (
	input logic resetReq,
	output logic clockVGA,
	output logic rstN
);

	initial clockVGA = 1'b0;

	always #halfPeriod clockVGA = ~clockVGA;

	// Reset edges land on the falling clock edge
	initial begin
		rstN = 1'b0;
		forever begin
			repeat (resetCycles) @(negedge clockVGA);
			rstN = 1'b1;
			@(negedge clockVGA);
			while (!resetReq)
				@(negedge clockVGA);
			rstN = 1'b0;
		end
	end

endmodule

// ==== tests/vgaDisplayTb.sv ====
`timescale 1ns/1ns

module vgaDisplayTb
	import vgaPkg::*;
();

	localparam int displayWidth = 8;
	localparam int displayHeight = 4;
	localparam int hSyncTime = 3;
	localparam int hBackTime = 2;
	localparam int hFrontTime = 2;
	localparam int vSyncTime = 1;
	localparam int vBackTime = 1;
	localparam int vFrontTime = 1;
	localparam int lineClocks = hSyncTime + hBackTime + displayWidth + hFrontTime;
	localparam int frameLines = vSyncTime + vBackTime + displayHeight + vFrontTime;
	localparam int frameClocks = lineClocks * frameLines;

	logic clockVGA;
	logic rstN;
	logic resetReq;
	logic hSyncN;
	logic vSyncN;
	logic [colorWidth-1:0] red;
	logic [colorWidth-1:0] green;
	logic [colorWidth-1:0] blue;
	logic underrun;

	// Clocks since reset release; the pins show counter state tick - 1
	int tick = 0;
	logic armed = 1'b0;
	logic lastWasReset = 1'b0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;

	clockGen #(.halfPeriod(2), .resetCycles(16)) i_clock (
		.resetReq(resetReq),
		.clockVGA(clockVGA),
		.rstN(rstN)
	);

	vgaDisplayTop #(
		.displayWidth(displayWidth),
		.displayHeight(displayHeight),
		.hSyncTime(hSyncTime),
		.hBackTime(hBackTime),
		.hFrontTime(hFrontTime),
		.vSyncTime(vSyncTime),
		.vBackTime(vBackTime),
		.vFrontTime(vFrontTime)
	) i_dut (
		.clockVGA(clockVGA),
		.rstN(rstN),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.red(red),
		.green(green),
		.blue(blue),
		.underrun(underrun)
	);

	always @(posedge clockVGA) begin
		armed <= 1'b1;
		lastWasReset <= !rstN;
		tick <= rstN ? tick + 1 : 0;
	end

	task automatic reportMismatch(input string name, input int expected, input int actual);
		errorCount++;
		$display("ERROR %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
	endtask

	// Pins are stable at the falling edge
	always @(negedge clockVGA) begin : checkPins
		int h;
		int v;
		int frame;
		logic inActive;
		logic expHSyncN;
		logic expVSyncN;
		logic [colorWidth-1:0] expRed;
		logic [colorWidth-1:0] expGreen;
		logic [colorWidth-1:0] expBlue;
		if (armed) begin
			h = (tick - 1) % lineClocks;
			v = ((tick - 1) / lineClocks) % frameLines;
			frame = (tick - 1) / frameClocks;
			inActive = !lastWasReset && h >= hSyncTime + hBackTime
				&& h < hSyncTime + hBackTime + displayWidth
				&& v >= vSyncTime + vBackTime
				&& v < vSyncTime + vBackTime + displayHeight;
			expHSyncN = lastWasReset || h >= hSyncTime;
			expVSyncN = lastWasReset || v >= vSyncTime;
			expRed = inActive ? colorWidth'(h - hSyncTime - hBackTime) : '0;
			expGreen = inActive ? colorWidth'(v - vSyncTime - vBackTime) : '0;
			expBlue = inActive ? colorWidth'(frame) : '0;
			checkCount++;
			assert (hSyncN == expHSyncN) else reportMismatch("hSyncN", expHSyncN, hSyncN);
			assert (vSyncN == expVSyncN) else reportMismatch("vSyncN", expVSyncN, vSyncN);
			assert (red == expRed) else reportMismatch("red", expRed, red);
			assert (green == expGreen) else reportMismatch("green", expGreen, green);
			assert (blue == expBlue) else reportMismatch("blue", expBlue, blue);
			assert (underrun == 1'b0) else reportMismatch("underrun", 0, underrun);
		end
	end

	task automatic abortRun(input string reason);
		$display("Timeout while waiting for %s", reason);
		$display("Some tests failed");
		$finish;
	endtask

	task automatic waitForReset(input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (rstN !== level && cycles < limit) begin
			@(posedge clockVGA);
			cycles++;
		end
		if (rstN !== level)
			abortRun(level ? "reset release" : "reset entry");
	endtask

	task automatic waitForTick(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (tick < target && cycles < limit) begin
			@(negedge clockVGA);
			cycles++;
		end
		if (tick < target)
			abortRun("the raster model to advance");
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("Test %s: pass", name);
		end else begin
			failedTests++;
			$display("Test %s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	initial begin : stimulus
		int framesToRun;
		int resetOffset;
		int errorsBefore;
		resetReq = 1'b0;
		void'($urandom(32'h5856bad9));
		framesToRun = 2 + ($urandom % 3);
		resetOffset = 20 + ($urandom % 70);

		errorsBefore = errorCount;
		waitForReset(1'b1, 40);
		waitForTick(1, 4);
		finishTest("reset state", errorsBefore);

		// Syncs, blanking, pattern and underrun across several frames
		errorsBefore = errorCount;
		waitForTick(framesToRun * frameClocks + 1, framesToRun * frameClocks + 10);
		finishTest("frames", errorsBefore);

		errorsBefore = errorCount;
		waitForTick(tick + resetOffset, resetOffset + 4);
		@(posedge clockVGA);
		resetReq = 1'b1;
		waitForReset(1'b0, 4);
		resetReq = 1'b0;
		waitForReset(1'b1, 24);
		waitForTick(1, 4);
		finishTest("mid-frame reset", errorsBefore);

		errorsBefore = errorCount;
		waitForTick(2 * frameClocks + 1, 2 * frameClocks + 10);
		finishTest("frames after reset", errorsBefore);

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
